// File: Makefile
TOP := fetch_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q '>>> FAIL' sim.log; then \
		echo "Simulation reported a failure"; \
		exit 1; \
	fi
	@if ! grep -q '>>> PASS' sim.log; then \
		echo "Simulation ended without completing"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: dv/fetch_assertions.sv
`timescale 1ns/1ps

module fetch_assertions
    import fetch_pkg::*;
(
    input logic     clk_i,
    input logic     rst_i,
    input logic     halt_i,
    input logic     jmp_valid_i,
    input logic     ready_i,
    input logic     valid_i,
    input word_t    pc_i,
    input word_t    ir_i,
    input word_t    pc_next_i,
    input logic     req_valid_i,
    input logic     req_fire_i,
    input memaddr_t req_addr_i
);

    // Pending request keeps its address
    req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        req_valid_i && !req_fire_i |=> req_valid_i && $stable(req_addr_i))
        else $error("Request address changed while waiting for req_ready");

    // Only a jump may drop the held output
    out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        valid_i && !ready_i && !jmp_valid_i |=>
            valid_i && $stable(pc_i) && $stable(ir_i) && $stable(pc_next_i))
        else $error("Output payload changed while waiting for ready_i");

    // Halt lets a waiting request finish but starts no new one
    halt_no_req: assert property (@(posedge clk_i) disable iff (rst_i)
        halt_i && (!req_valid_i || req_fire_i) |=> !req_valid_i)
        else $error("New request issued while halt_i was high");

endmodule

bind fetch_stage fetch_assertions u_assertions (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .halt_i      (halt_i),
    .jmp_valid_i (jmp_valid_i),
    .ready_i     (ready_i),
    .valid_i     (valid_o),
    .pc_i        (pc_o),
    .ir_i        (ir_o),
    .pc_next_i   (pc_next_o),
    .req_valid_i (req_valid_q),
    .req_fire_i  (req_fire),
    .req_addr_i  (req_addr_q)
);

// File: dv/fetch_clkgen.sv
`timescale 1ns/1ps

module fetch_clkgen (
    output logic clk_o,
    output logic rst_o
);

    // 10 ns period, first rising edge at 5 ns
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    // Held over three rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule

// File: dv/fetch_tb.sv
`timescale 1ns/1ps

`include "fetch_macros.svh"

module fetch_tb
    import fetch_pkg::*;
();

    typedef struct packed {
        logic        do_jump;
        word_t       target;
        int          count;
        int unsigned ready_pct;
        int          halt_cycles;
    } scenario_t;

    logic      clk;
    logic      rst;
    logic      halt;
    word_t     jmp_addr;
    logic      jmp_valid;
    logic      ready;
    word_t     pc;
    word_t     ir;
    word_t     pc_next;
    logic      valid;
    word_t     image [`FETCH_MEM_WORDS];
    word_t     model_pc;
    scenario_t scen [5];
    int        limit;

    fetch_clkgen u_clkgen (
        .clk_o (clk),
        .rst_o (rst)
    );

    fetch_top DUT (
        .clk_i       (clk),
        .rst_i       (rst),
        .halt_i      (halt),
        .jmp_addr_i  (jmp_addr),
        .jmp_valid_i (jmp_valid),
        .pc_o        (pc),
        .ir_o        (ir),
        .pc_next_o   (pc_next),
        .valid_o     (valid),
        .ready_i     (ready)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "fetch testbench stopped on first error");
    endtask

    task automatic check_value(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAIL %s: got 0x%08h, expected 0x%08h",
                                        name, got, exp));
        end
    endtask

    function automatic logic [15:0] halfword_at(input word_t addr);
        word_t w;
        w = image[memaddr_t'(addr >> 2)];
        return addr[1] ? w[31:16] : w[15:0];
    endfunction

    // Full instructions take the next halfword as their upper half
    function automatic word_t predict_ir(input word_t addr);
        logic [15:0] lo;
        lo = halfword_at(addr);
        if (lo[1:0] != 2'b11) begin
            return {16'h0000, lo};
        end
        return {halfword_at(addr + 32'd2), lo};
    endfunction

    task automatic compare_output();
        word_t exp_ir;
        word_t exp_next;
        exp_ir   = predict_ir(model_pc);
        exp_next = model_pc + ((exp_ir[1:0] != 2'b11) ? 32'd2 : 32'd4);
        check_value("pc_o", pc, model_pc);
        check_value("ir_o", ir, exp_ir);
        check_value("pc_next_o", pc_next, exp_next);
        model_pc = exp_next;
    endtask

    task automatic run_row(input scenario_t s);
        int   taken;
        int   halt_left;
        int   halt_accepts;
        logic halt_used;
        taken        = 0;
        halt_left    = 0;
        halt_accepts = 0;
        halt_used    = 1'b0;
        if (s.do_jump) begin
            ready     = 1'b0;
            jmp_addr  = s.target;
            jmp_valid = 1'b1;
            @(negedge clk);
            jmp_valid = 1'b0;
            check_value("valid_o", word_t'(valid), 32'h0);
            model_pc = s.target;
        end
        while (taken < s.count) begin
            if (s.halt_cycles > 0 && !halt_used && taken == s.count / 2) begin
                halt_used = 1'b1;
                halt      = 1'b1;
                halt_left = s.halt_cycles;
            end
            ready = ($urandom_range(99) < s.ready_pct);
            // Handshake happens on the coming rising edge
            if (valid && ready) begin
                compare_output();
                taken++;
                if (halt) begin
                    halt_accepts++;
                end
            end
            @(negedge clk);
            if (halt) begin
                halt_left--;
                if (halt_left == 0) begin
                    halt = 1'b0;
                    if (halt_accepts > 1) begin
                        stop_with_failure($sformatf(
                            "%0d instructions were accepted while fetch was halted",
                            halt_accepts));
                    end
                end
            end
        end
        halt  = 1'b0;
        ready = 1'b0;
    endtask

    initial begin
        halt      = 1'b0;
        jmp_addr  = '0;
        jmp_valid = 1'b0;
        ready     = 1'b0;
        void'($urandom(50996));
        $readmemh("dv/prog.hex", image);
        model_pc = `FETCH_RESET_PC;

        // Jump, target, count, ready percent, halt cycles
        scen[0] = '{1'b0, 32'h0000_0000, 17, 100, 0};
        scen[1] = '{1'b1, 32'h0000_0000, 17, 50, 0};
        scen[2] = '{1'b1, 32'h0000_0018, 9, 70, 0};
        scen[3] = '{1'b1, 32'h0000_000e, 12, 60, 0};
        scen[4] = '{1'b1, 32'h0000_0006, 15, 80, 12};

        limit = 200;
        foreach (scen[i]) begin
            limit += scen[i].count * 20;
        end
        fork
            begin
                repeat (limit) @(posedge clk);
                stop_with_failure($sformatf("Run timed out after %0d cycles", limit));
            end
        join_none

        // Three reset cycles plus the first cycle after release
        @(posedge clk);
        repeat (4) begin
            @(negedge clk);
            check_value("valid_o", word_t'(valid), 32'h0);
        end

        foreach (scen[i]) begin
            run_row(scen[i]);
        end

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: dv/prog.hex
// One 32-bit instruction word per line, from word address 0 upward
// Low halfword holds the lower byte address; RVC and full encodings mixed
00100093
81334505
05050020
00b38082
82330031
46810041
00500313
078d0705
00628433
00ef4781
079101c0
00c58593
05854585
00b50533

// File: src.f
+incdir+src
src/fetch_pkg.sv
src/icache_if.sv
src/fetch_aligner.sv
src/fetch_stage.sv
src/imem_model.sv
src/fetch_top.sv
dv/fetch_clkgen.sv
dv/fetch_assertions.sv
dv/fetch_tb.sv

// File: src/fetch_aligner.sv
`timescale 1ns/1ps

module fetch_aligner
    import fetch_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  flush_i,
    input  word_t word_i,
    input  logic  word_valid_i,
    output logic  word_ready_o,
    input  logic  take_i,
    output word_t insn_o,
    output logic  insn_valid_o,
    output logic  compressed_o,
    input  logic  skip_low_i
);

    word_t        buf_q;
    align_state_t state_q;
    align_state_t state_d;
    logic         skip_q;
    logic         accept;
    logic [15:0]  lo_half;
    logic [15:0]  hi_half;

    // Pick the two candidate halfwords for the next instruction
    always_comb begin
        case (state_q)
            ALIGN_HALF: begin
                lo_half = buf_q[31:16];
                hi_half = word_i[15:0];
            end
            ALIGN_FULL: begin
                lo_half = buf_q[15:0];
                hi_half = buf_q[31:16];
            end
            default: begin
                lo_half = word_i[15:0];
                hi_half = word_i[31:16];
            end
        endcase
    end

    // RVC encodings never end in 2'b11
    assign compressed_o = lo_half[1:0] != 2'b11;
    assign insn_o       = {compressed_o ? 16'h0000 : hi_half, lo_half};

    always_comb begin
        case (state_q)
            ALIGN_EMPTY: insn_valid_o = word_valid_i && !skip_q;
            ALIGN_HALF:  insn_valid_o = compressed_o || word_valid_i;
            ALIGN_FULL:  insn_valid_o = 1'b1;
            default:     insn_valid_o = 1'b0;
        endcase
    end

    // Only take a word when it fits next to what stays buffered
    always_comb begin
        case (state_q)
            ALIGN_EMPTY: word_ready_o = 1'b1;
            ALIGN_HALF:  word_ready_o = take_i;
            ALIGN_FULL:  word_ready_o = take_i && !compressed_o;
            default:     word_ready_o = 1'b0;
        endcase
    end

    assign accept = word_valid_i && word_ready_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ALIGN_EMPTY: begin
                if (accept) begin
                    if (skip_q) begin
                        state_d = ALIGN_HALF;
                    end else if (take_i) begin
                        state_d = compressed_o ? ALIGN_HALF : ALIGN_EMPTY;
                    end else begin
                        state_d = ALIGN_FULL;
                    end
                end
            end
            ALIGN_HALF: begin
                if (take_i && accept) begin
                    // Straddling insn leaves the new upper half behind
                    state_d = compressed_o ? ALIGN_FULL : ALIGN_HALF;
                end else if (take_i) begin
                    state_d = ALIGN_EMPTY;
                end
            end
            ALIGN_FULL: begin
                if (take_i && !accept) begin
                    state_d = compressed_o ? ALIGN_HALF : ALIGN_EMPTY;
                end
            end
            default: state_d = ALIGN_EMPTY;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ALIGN_EMPTY;
            skip_q  <= 1'b0;
        end else if (flush_i) begin
            state_q <= ALIGN_EMPTY;
            skip_q  <= skip_low_i;
        end else begin
            state_q <= state_d;
            if (accept) begin
                skip_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            buf_q <= word_i;
        end
    end

endmodule

// File: src/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Instruction and PC width
`define FETCH_XLEN 32

// ROM depth in words
`define FETCH_MEM_WORDS 64

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

// File: src/fetch_pkg.sv
`include "fetch_macros.svh"

package fetch_pkg;

    // One instruction word or a byte-address PC
    typedef logic [`FETCH_XLEN-1:0] word_t;

    // Word index into instruction memory
    typedef logic [$clog2(`FETCH_MEM_WORDS)-1:0] memaddr_t;

    // Unused halfwords held in the realign buffer
    //   ALIGN_HALF means only the upper half of the buffer is still pending
    typedef enum logic [1:0] {
        ALIGN_EMPTY = 2'b00,
        ALIGN_HALF  = 2'b01,
        ALIGN_FULL  = 2'b10
    } align_state_t;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/1ps

`include "fetch_macros.svh"

module fetch_stage
    import fetch_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    halt_i,
    input  word_t   jmp_addr_i,
    input  logic    jmp_valid_i,
    icache_if.fetch icache,
    output word_t   pc_o,
    output word_t   ir_o,
    output word_t   pc_next_o,
    output logic    valid_o,
    input  logic    ready_i
);

    localparam memaddr_t RESET_WORD = memaddr_t'(`FETCH_RESET_PC >> 2);

    memaddr_t   req_addr_q;
    memaddr_t   nxt_addr_q;
    memaddr_t   exp_addr_q;
    memaddr_t   jmp_word;
    memaddr_t   load_addr;
    logic       req_valid_q;
    logic [2:0] cnt_q;
    logic       req_fire;
    logic       resp_fire;
    logic       new_req;
    logic       resp_open;
    logic       stale;
    word_t      fetch_pc_q;
    word_t      pc_q;
    word_t      ir_q;
    word_t      pc_next_q;
    logic       valid_q;
    word_t      insn;
    logic       insn_valid;
    logic       compressed;
    logic       word_ready;
    logic       take;
    word_t      pc_step;

    assign jmp_word  = memaddr_t'(jmp_addr_i >> 2);
    assign load_addr = jmp_valid_i ? jmp_word : nxt_addr_q;
    assign req_fire  = icache.req_valid && icache.req_ready;
    assign resp_fire = icache.resp_valid && icache.resp_ready;

    // At most four words between presented and returned
    assign new_req = (!req_valid_q || req_fire) && !halt_i &&
                     ((cnt_q + 3'(req_valid_q)) < 3'd4);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            req_valid_q <= 1'b0;
            nxt_addr_q  <= RESET_WORD;
            cnt_q       <= '0;
        end else begin
            if (new_req) begin
                req_valid_q <= 1'b1;
                nxt_addr_q  <= load_addr + memaddr_t'(1);
            end else begin
                if (req_fire) begin
                    req_valid_q <= 1'b0;
                end
                // A waiting request keeps its address, the target goes next
                if (jmp_valid_i) begin
                    nxt_addr_q <= jmp_word;
                end
            end
            cnt_q <= cnt_q + 3'(req_fire) - 3'(resp_fire);
        end
    end

    always_ff @(posedge clk_i) begin
        if (new_req) begin
            req_addr_q <= load_addr;
        end
    end

    assign icache.req_addr  = req_addr_q;
    assign icache.req_valid = req_valid_q;

    // Drop responses that are not the next expected word
    assign stale     = icache.resp_addr != exp_addr_q;
    assign resp_open = cnt_q != 3'd0;
    assign icache.resp_ready = resp_open && (stale || word_ready);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            exp_addr_q <= RESET_WORD;
        end else if (jmp_valid_i) begin
            exp_addr_q <= jmp_word;
        end else if (resp_fire && !stale) begin
            exp_addr_q <= exp_addr_q + memaddr_t'(1);
        end
    end

    fetch_aligner u_aligner (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flush_i      (jmp_valid_i),
        .word_i       (icache.resp_data),
        .word_valid_i (icache.resp_valid && resp_open && !stale),
        .word_ready_o (word_ready),
        .take_i       (take),
        .insn_o       (insn),
        .insn_valid_o (insn_valid),
        .compressed_o (compressed),
        .skip_low_i   (jmp_addr_i[1])
    );

    // Load when the output slot is free or being emptied
    assign take    = insn_valid && (!valid_q || ready_i) && !halt_i && !jmp_valid_i;
    assign pc_step = compressed ? word_t'(2) : word_t'(4);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q    <= 1'b0;
            fetch_pc_q <= `FETCH_RESET_PC;
        end else if (jmp_valid_i) begin
            valid_q    <= 1'b0;
            fetch_pc_q <= jmp_addr_i;
        end else if (take) begin
            valid_q    <= 1'b1;
            fetch_pc_q <= fetch_pc_q + pc_step;
        end else if (ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            pc_q      <= fetch_pc_q;
            ir_q      <= insn;
            pc_next_q <= fetch_pc_q + pc_step;
        end
    end

    assign pc_o      = pc_q;
    assign ir_o      = ir_q;
    assign pc_next_o = pc_next_q;
    assign valid_o   = valid_q;

endmodule

// File: src/fetch_top.sv
`timescale 1ns/1ps

module fetch_top
    import fetch_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    input  logic  halt_i,
    input  word_t jmp_addr_i,
    input  logic  jmp_valid_i,
    output word_t pc_o,
    output word_t ir_o,
    output word_t pc_next_o,
    output logic  valid_o,
    input  logic  ready_i
);

    // Fetch to instruction memory link
    icache_if icache ();

    fetch_stage u_fetch (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .halt_i      (halt_i),
        .jmp_addr_i  (jmp_addr_i),
        .jmp_valid_i (jmp_valid_i),
        .icache      (icache.fetch),
        .pc_o        (pc_o),
        .ir_o        (ir_o),
        .pc_next_o   (pc_next_o),
        .valid_o     (valid_o),
        .ready_i     (ready_i)
    );

    imem_model u_imem (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .icache (icache.mem)
    );

endmodule

// File: src/icache_if.sv
`timescale 1ns/1ps

interface icache_if
    import fetch_pkg::*;
();

    // Request channel
    memaddr_t req_addr;
    logic     req_valid;
    logic     req_ready;

    // Response channel, in request order
    memaddr_t resp_addr;
    word_t    resp_data;
    logic     resp_valid;
    logic     resp_ready;

    modport fetch (
        output req_addr, req_valid, resp_ready,
        input  req_ready, resp_addr, resp_data, resp_valid
    );

    modport mem (
        input  req_addr, req_valid, resp_ready,
        output req_ready, resp_addr, resp_data, resp_valid
    );

endinterface

// File: src/imem_model.sv
`timescale 1ns/1ps

`include "fetch_macros.svh"

module imem_model
    import fetch_pkg::*;
(
    input  logic  clk_i,
    input  logic  rst_i,
    icache_if.mem icache
);

    localparam int QDEPTH = 4;

    word_t      rom [`FETCH_MEM_WORDS];
    logic       s1_valid_q;
    memaddr_t   s1_addr_q;
    logic       s2_valid_q;
    memaddr_t   s2_addr_q;
    word_t      s2_data_q;
    memaddr_t   q_addr [QDEPTH];
    word_t      q_data [QDEPTH];
    logic [1:0] wr_ptr_q;
    logic [1:0] rd_ptr_q;
    logic [2:0] q_cnt_q;
    logic [2:0] occ_q;
    logic       req_fire;
    logic       resp_fire;

    initial begin
        $readmemh("dv/prog.hex", rom);
    end

    assign req_fire  = icache.req_valid && icache.req_ready;
    assign resp_fire = icache.resp_valid && icache.resp_ready;

    // Words in the read pipe count too, so the queue cannot overflow
    assign icache.req_ready = occ_q < 3'(QDEPTH);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            s1_valid_q <= 1'b0;
            s2_valid_q <= 1'b0;
            wr_ptr_q   <= '0;
            rd_ptr_q   <= '0;
            q_cnt_q    <= '0;
            occ_q      <= '0;
        end else begin
            s1_valid_q <= req_fire;
            s2_valid_q <= s1_valid_q;
            wr_ptr_q   <= wr_ptr_q + 2'(s2_valid_q);
            rd_ptr_q   <= rd_ptr_q + 2'(resp_fire);
            q_cnt_q    <= q_cnt_q + 3'(s2_valid_q) - 3'(resp_fire);
            occ_q      <= occ_q + 3'(req_fire) - 3'(resp_fire);
        end
    end

    // Two-stage read, then into the queue
    always_ff @(posedge clk_i) begin
        s1_addr_q <= icache.req_addr;
        s2_addr_q <= s1_addr_q;
        s2_data_q <= rom[s1_addr_q];
        if (s2_valid_q) begin
            q_addr[wr_ptr_q] <= s2_addr_q;
            q_data[wr_ptr_q] <= s2_data_q;
        end
    end

    assign icache.resp_valid = q_cnt_q != 3'd0;
    assign icache.resp_addr  = q_addr[rd_ptr_q];
    assign icache.resp_data  = q_data[rd_ptr_q];

endmodule
